/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int wordSize = 16;

    typedef logic [wordSize-1:0] wordT;
    typedef logic [1:0]          regAddrT;
    typedef logic [7:0]          immT;        // short immediate field
    typedef logic [11:0]         jumpT;       // JMP target field

    // instruction word layout
    localparam int opcodeMsb = 15;
    localparam int opcodeLsb = 12;
    localparam int rsMsb     = 11;
    localparam int rsLsb     = 10;
    localparam int rtMsb     = 9;
    localparam int rtLsb     = 8;
    localparam int rdMsb     = 7;
    localparam int rdLsb     = 6;
    localparam int funcMsb   = 5;
    localparam int funcLsb   = 0;
    localparam int immMsb    = 7;
    localparam int jumpMsb   = 11;

    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opBgz   = 4'd2,
        opBlz   = 4'd3,
        opAdi   = 4'd4,
        opOri   = 4'd5,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opRtype = 4'd15
    } opcodeT;

    typedef enum logic [5:0] {
        funcAdd = 6'd0,
        funcSub = 6'd1,
        funcAnd = 6'd2,
        funcOrr = 6'd3,
        funcNot = 6'd4,
        funcTcp = 6'd5,
        funcShl = 6'd6,
        funcShr = 6'd7,
        funcWwd = 6'd28,
        funcHlt = 6'd29
    } funcT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluTcp,
        aluShl,
        aluShr,
        aluPassB,
        aluLhi
    } aluOpT;

    typedef enum logic [2:0] {
        brNone,
        brNe,
        brEq,
        brGz,
        brLz,
        brJump
    } branchT;

endpackage

`default_nettype wire

/* fetchStage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchStage #(
    parameter cpuPkg::wordT resetPc = '0
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         stall,
    input  logic         redirect,
    input  cpuPkg::wordT redirectPc,
    input  logic         haltSeen,
    input  cpuPkg::wordT instrData,
    output cpuPkg::wordT instrAddr,
    output logic         instrRead,
    output cpuPkg::wordT idInstr,
    output cpuPkg::wordT idPc,
    output logic         idValid
);
    import cpuPkg::*;

    wordT pc;
    wordT pcPlusOne;
    logic advance;

    assign pcPlusOne = pc + {{(wordSize-1){1'b0}}, 1'b1};
    assign advance   = !stall && !haltSeen;   // fetch frozen on load-use or after HLT
    assign instrAddr = pc;
    assign instrRead = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= resetPc;
            idValid <= 1'b0;
        end else if (redirect) begin
            pc      <= redirectPc;
            idValid <= 1'b0;                  // drop the wrong-path fetch
        end else if (advance) begin
            pc      <= pcPlusOne;
            idValid <= 1'b1;
        end else if (haltSeen) begin
            idValid <= 1'b0;                  // nothing issues behind HLT
        end
    end

    // IF/ID payload, held while stalled
    always_ff @(posedge clk) begin
        if (advance) begin
            idInstr <= instrData;
            idPc    <= pcPlusOne;             // branch base is PC+1
        end
    end

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::wordT    idInstr,
    input  logic            idValid,
    input  cpuPkg::regAddrT exRd,
    input  logic            exMemRead,
    input  logic            exValid,
    output cpuPkg::regAddrT rs,
    output cpuPkg::regAddrT rt,
    output cpuPkg::regAddrT rd,
    output cpuPkg::wordT    imm,
    output cpuPkg::aluOpT   aluOp,
    output cpuPkg::branchT  branch,
    output logic            useImm,
    output logic            regWrite,
    output logic            memRead,
    output logic            memWrite,
    output logic            isWwd,
    output logic            isHalt,
    output logic            stall,
    output logic            haltSeen
);
    import cpuPkg::*;

    opcodeT opcode;
    funcT   func;
    immT    immField;
    jumpT   jumpField;
    logic   readsRs;
    logic   readsRt;
    logic   haltSeenReg;

    assign opcode    = opcodeT'(idInstr[opcodeMsb:opcodeLsb]);
    assign func      = funcT'(idInstr[funcMsb:funcLsb]);
    assign immField  = idInstr[immMsb:0];
    assign jumpField = idInstr[jumpMsb:0];
    assign rs        = idInstr[rsMsb:rsLsb];

    always_comb begin
        rt       = idInstr[rtMsb:rtLsb];
        rd       = idInstr[rtMsb:rtLsb];                      // I-type and LWD write rt
        imm      = {{(wordSize-8){immField[immMsb]}}, immField};
        aluOp    = aluAdd;
        branch   = brNone;
        useImm   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        isWwd    = 1'b0;
        isHalt   = 1'b0;
        readsRs  = 1'b1;
        readsRt  = 1'b0;
        case (opcode)
            opBne: begin
                branch  = brNe;
                readsRt = 1'b1;
            end
            opBeq: begin
                branch  = brEq;
                readsRt = 1'b1;
            end
            opBgz: branch = brGz;
            opBlz: branch = brLz;
            opAdi: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            opOri: begin
                imm      = {{(wordSize-8){1'b0}}, immField};  // zero extended
                aluOp    = aluOr;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            opLhi: begin
                imm      = {{(wordSize-8){1'b0}}, immField};
                aluOp    = aluLhi;
                useImm   = 1'b1;
                regWrite = 1'b1;
                readsRs  = 1'b0;
            end
            opLwd: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            opSwd: begin
                useImm   = 1'b1;
                memWrite = 1'b1;
                readsRt  = 1'b1;                              // store data
            end
            opJmp: begin
                imm     = {{(wordSize-12){1'b0}}, jumpField};
                branch  = brJump;
                readsRs = 1'b0;
            end
            opRtype: begin
                rd       = idInstr[rdMsb:rdLsb];
                regWrite = 1'b1;
                case (func)
                    funcAdd: readsRt = 1'b1;
                    funcSub: begin
                        aluOp   = aluSub;
                        readsRt = 1'b1;
                    end
                    funcAnd: begin
                        aluOp   = aluAnd;
                        readsRt = 1'b1;
                    end
                    funcOrr: begin
                        aluOp   = aluOr;
                        readsRt = 1'b1;
                    end
                    funcNot: aluOp = aluNot;
                    funcTcp: aluOp = aluTcp;
                    funcShl: aluOp = aluShl;
                    funcShr: aluOp = aluShr;
                    funcWwd: begin
                        rt       = idInstr[rsMsb:rsLsb];          // rs value rides the B path
                        aluOp    = aluPassB;
                        regWrite = 1'b0;
                        isWwd    = 1'b1;
                    end
                    funcHlt: begin
                        regWrite = 1'b0;
                        isHalt   = 1'b1;
                        readsRs  = 1'b0;
                    end
                    default: regWrite = 1'b0;                 // unknown func acts as nop
                endcase
            end
            default: readsRs = 1'b0;
        endcase
    end

    // load in EX feeding a source read in ID
    assign stall = idValid && exValid && exMemRead &&
                   ((readsRs && exRd == rs) || (readsRt && exRd == rt));

    always_ff @(posedge clk) begin
        if (reset) begin
            haltSeenReg <= 1'b0;
        end else if (idValid && isHalt) begin
            haltSeenReg <= 1'b1;
        end
    end

    assign haltSeen = haltSeenReg || (idValid && isHalt);  // freeze fetch in the HLT decode cycle

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::regAddrT rs,
    input  cpuPkg::regAddrT rt,
    input  logic            wbWrite,
    input  cpuPkg::regAddrT wbRd,
    input  cpuPkg::wordT    wbData,
    output cpuPkg::wordT    rsData,
    output cpuPkg::wordT    rtData
);
    import cpuPkg::*;

    localparam int numRegs = 2 ** $bits(regAddrT);

    wordT regs [numRegs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= {wordSize{1'b0}};
            end
        end else if (wbWrite) begin
            regs[wbRd] <= wbData;
        end
    end

    // same-cycle writeback bypasses to the readers
    assign rsData = (wbWrite && wbRd == rs) ? wbData : regs[rs];
    assign rtData = (wbWrite && wbRd == rt) ? wbData : regs[rt];

endmodule

`default_nettype wire

/* executeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module executeStage (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::regAddrT rs,
    input  cpuPkg::regAddrT rt,
    input  cpuPkg::regAddrT rd,
    input  cpuPkg::wordT    imm,
    input  cpuPkg::aluOpT   aluOp,
    input  cpuPkg::branchT  branch,
    input  logic            useImm,
    input  logic            regWrite,
    input  logic            memRead,
    input  logic            memWrite,
    input  logic            isWwd,
    input  logic            isHalt,
    input  logic            stall,
    input  cpuPkg::wordT    rsData,
    input  cpuPkg::wordT    rtData,
    input  cpuPkg::wordT    idPc,
    input  logic            idValid,
    input  logic            memFwdWrite,
    input  cpuPkg::regAddrT memRd,
    input  cpuPkg::wordT    memFwdData,
    input  logic            wbWrite,
    input  cpuPkg::regAddrT wbRd,
    input  cpuPkg::wordT    wbData,
    output logic            redirect,
    output cpuPkg::wordT    redirectPc,
    output cpuPkg::regAddrT exRd,
    output logic            exMemRead,
    output logic            exValid,
    output cpuPkg::wordT    memAluResult,
    output cpuPkg::wordT    memStoreData,
    output cpuPkg::regAddrT memRdOut,
    output logic            memRegWrite,
    output logic            memMemRead,
    output logic            memMemWrite,
    output logic            memIsWwd,
    output logic            memIsHalt,
    output logic            memValid
);
    import cpuPkg::*;

    regAddrT exRs;
    regAddrT exRt;
    wordT    exImm;
    wordT    exRsData;
    wordT    exRtData;
    wordT    exPc;
    aluOpT   exAluOp;
    branchT  exBranch;
    logic    exUseImm;
    logic    exRegWrite;
    logic    exMemWrite;
    logic    exIsWwd;
    logic    exIsHalt;
    wordT    opA;
    wordT    rtFwd;
    wordT    opB;
    wordT    aluResult;
    logic    taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid  <= 1'b0;
            memValid <= 1'b0;
        end else begin
            exValid  <= idValid && !stall && !redirect;   // bubble on load-use or flush
            memValid <= exValid;
        end
    end

    // ID/EX and EX/MEM payload
    always_ff @(posedge clk) begin
        exRs         <= rs;
        exRt         <= rt;
        exRd         <= rd;
        exImm        <= imm;
        exRsData     <= rsData;
        exRtData     <= rtData;
        exPc         <= idPc;
        exAluOp      <= aluOp;
        exBranch     <= branch;
        exUseImm     <= useImm;
        exRegWrite   <= regWrite;
        exMemRead    <= memRead;
        exMemWrite   <= memWrite;
        exIsWwd      <= isWwd;
        exIsHalt     <= isHalt;
        memAluResult <= aluResult;
        memStoreData <= rtFwd;
        memRdOut     <= exRd;
        memRegWrite  <= exRegWrite;
        memMemRead   <= exMemRead;
        memMemWrite  <= exMemWrite;
        memIsWwd     <= exIsWwd;
        memIsHalt    <= exIsHalt;
    end

    // youngest producer wins
    assign opA   = (memFwdWrite && memRd == exRs) ? memFwdData :
                   (wbWrite && wbRd == exRs)      ? wbData     : exRsData;
    assign rtFwd = (memFwdWrite && memRd == exRt) ? memFwdData :
                   (wbWrite && wbRd == exRt)      ? wbData     : exRtData;
    assign opB   = exUseImm ? exImm : rtFwd;

    always_comb begin
        case (exAluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluAnd:   aluResult = opA & opB;
            aluOr:    aluResult = opA | opB;
            aluNot:   aluResult = ~opA;
            aluTcp:   aluResult = -opA;
            aluShl:   aluResult = opA << 1;
            aluShr:   aluResult = {opA[wordSize-1], opA[wordSize-1:1]};  // arithmetic shift
            aluPassB: aluResult = opB;
            aluLhi:   aluResult = opB << 8;
            default:  aluResult = '0;
        endcase
    end

    always_comb begin
        case (exBranch)
            brNe:    taken = opA != rtFwd;
            brEq:    taken = opA == rtFwd;
            brGz:    taken = !opA[wordSize-1] && opA != '0;
            brLz:    taken = opA[wordSize-1];
            brJump:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect   = exValid && taken;
    assign redirectPc = (exBranch == brJump) ? {exPc[wordSize-1:jumpMsb+1], exImm[jumpMsb:0]}
                                             : exPc + exImm;

endmodule

`default_nettype wire

/* memWbStage.sv */
`timescale 1ns/10ps
`default_nettype none

module memWbStage (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::wordT    memAluResult,
    input  cpuPkg::wordT    memStoreData,
    input  cpuPkg::regAddrT memRdOut,
    input  logic            memRegWrite,
    input  logic            memMemRead,
    input  logic            memMemWrite,
    input  logic            memIsWwd,
    input  logic            memIsHalt,
    input  logic            memValid,
    input  cpuPkg::wordT    dataRdata,
    output cpuPkg::wordT    dataAddr,
    output logic            dataRead,
    output logic            dataWrite,
    output cpuPkg::wordT    dataWdata,
    output logic            memFwdWrite,
    output cpuPkg::regAddrT memRd,
    output cpuPkg::wordT    memFwdData,
    output logic            wbWrite,
    output cpuPkg::regAddrT wbRd,
    output cpuPkg::wordT    wbData,
    output cpuPkg::wordT    numInst,
    output cpuPkg::wordT    outputPort,
    output logic            halted
);
    import cpuPkg::*;

    logic wbValid;
    logic wbRegWrite;
    logic wbIsWwd;
    logic wbIsHalt;

    assign dataAddr  = memAluResult;
    assign dataRead  = memValid && memMemRead;
    assign dataWrite = memValid && memMemWrite;
    assign dataWdata = memStoreData;

    // a load has no result for EX yet
    assign memFwdWrite = memValid && memRegWrite && !memMemRead;
    assign memRd       = memRdOut;
    assign memFwdData  = memAluResult;

    assign wbWrite = wbValid && wbRegWrite;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid    <= 1'b0;
            numInst    <= {wordSize{1'b0}};
            outputPort <= {wordSize{1'b0}};
            halted     <= 1'b0;
        end else begin
            wbValid <= memValid;
            if (wbValid) begin
                numInst <= numInst + 1'b1;   // retire count
            end
            if (wbValid && wbIsWwd) begin
                outputPort <= wbData;
            end
            if (wbValid && wbIsHalt) begin
                halted <= 1'b1;              // sticky until reset
            end
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        wbRegWrite <= memRegWrite;
        wbIsWwd    <= memIsWwd;
        wbIsHalt   <= memIsHalt;
        wbRd       <= memRdOut;
        wbData     <= memMemRead ? dataRdata : memAluResult;
    end

endmodule

`default_nettype wire

/* cpuCore.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuCore #(
    parameter cpuPkg::wordT resetPc = '0
) (
    input  logic         clk,
    input  logic         reset,
    output cpuPkg::wordT instrAddr,
    output logic         instrRead,
    input  cpuPkg::wordT instrData,
    output cpuPkg::wordT dataAddr,
    output logic         dataRead,
    output logic         dataWrite,
    output cpuPkg::wordT dataWdata,
    input  cpuPkg::wordT dataRdata,
    output cpuPkg::wordT numInst,
    output cpuPkg::wordT outputPort,
    output logic         halted
);
    import cpuPkg::*;

    // IF/ID
    wordT    idInstr;
    wordT    idPc;
    logic    idValid;

    // decode results
    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
    wordT    imm;
    aluOpT   aluOp;
    branchT  branch;
    logic    useImm;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    isWwd;
    logic    isHalt;
    logic    stall;
    logic    haltSeen;
    wordT    rsData;
    wordT    rtData;

    // EX stage feedback
    logic    redirect;
    wordT    redirectPc;
    regAddrT exRd;
    logic    exMemRead;
    logic    exValid;

    // EX/MEM
    wordT    memAluResult;
    wordT    memStoreData;
    regAddrT memRdOut;
    logic    memRegWrite;
    logic    memMemRead;
    logic    memMemWrite;
    logic    memIsWwd;
    logic    memIsHalt;
    logic    memValid;

    // forwarding and writeback
    logic    memFwdWrite;
    regAddrT memRd;
    wordT    memFwdData;
    logic    wbWrite;
    regAddrT wbRd;
    wordT    wbData;

    fetchStage #(
        .resetPc(resetPc)
    ) fetch0 (.*);

    controlUnit decode0 (.*);

    regFile regs0 (.*);

    executeStage execute0 (.*);

    memWbStage memWb0 (.*);

endmodule

`default_nettype wire

/* cpuCore_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuCore_chk (
    input logic         clk,
    input logic         reset,
    input logic         dataRead,
    input logic         dataWrite,
    input logic         halted,
    input cpuPkg::wordT numInst
);
    import cpuPkg::*;

    // one access per cycle on the data port
    noReadAndWrite: assert property (@(posedge clk) disable iff (reset)
        !(dataRead && dataWrite))
        else $error("data port read and write high in the same cycle");

    haltSticky: assert property (@(posedge clk) disable iff (reset)
        !$fell(halted))
        else $error("halted fell while reset was low");

    retireStep: assert property (@(posedge clk) disable iff (reset)
        numInst == $past(numInst) || numInst == wordT'($past(numInst) + 1'b1))
        else $error("numInst moved by more than one in a cycle");

    // nothing retires behind HLT
    retireFrozen: assert property (@(posedge clk) disable iff (reset)
        $past(halted) |-> numInst == $past(numInst))
        else $error("numInst changed while halted");

endmodule

bind cpuCore cpuCore_chk chk0 (.*);

`default_nettype wire

/* cpuCore_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuCore_tb;
    import cpuPkg::*;

    localparam int numTests   = 7;
    localparam int maxWords   = 16;
    localparam int cycleLimit = numTests * (maxWords * 4 + 20);
    localparam int memDepth   = 2 ** wordSize;
    localparam logic [31:0] lcgSeed = 32'h4641_7137;

    typedef enum logic [1:0] {memNone, memLoad, memStore} memCheckT;

    logic clk;
    logic reset;
    wordT instrAddr;
    logic instrRead;
    wordT instrData;
    wordT dataAddr;
    logic dataRead;
    logic dataWrite;
    wordT dataWdata;
    wordT dataRdata;
    wordT numInst;
    wordT outputPort;
    logic halted;

    wordT imem [memDepth];
    wordT dmem [memDepth];
    int   cycles = 0;

    // test table
    string    testName [numTests];
    wordT     prog     [numTests][maxWords];
    int       progLen  [numTests];
    wordT     expOut   [numTests];
    wordT     expCount [numTests];
    memCheckT memCheck [numTests];
    wordT     memAddr  [numTests];
    int       curTest = 0;
    int       curWord = 0;

    cpuCore #(
        .resetPc('0)
    ) dut0 (
        .clk(clk),
        .reset(reset),
        .instrAddr(instrAddr),
        .instrRead(instrRead),
        .instrData(instrData),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .dataRdata(dataRdata),
        .numInst(numInst),
        .outputPort(outputPort),
        .halted(halted)
    );

    always #5 clk = ~clk;

    // single-cycle memories, combinational read
    assign instrData = imem[instrAddr];
    assign dataRdata = dataRead ? dmem[dataAddr] : '0;  // data answers only a read strobe

    always @(posedge clk) begin
        if (dataWrite) begin
            dmem[dataAddr] <= dataWdata;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            stopRun($sformatf("timeout after %0d cycles, the core did not halt", cycles));
        end
    end

    function automatic logic [31:0] nextLcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic wordT encodeR(input funcT func, input regAddrT rs, input regAddrT rt,
                                     input regAddrT rd);
        return {opRtype, rs, rt, rd, func};
    endfunction

    function automatic wordT encodeI(input opcodeT op, input regAddrT rs, input regAddrT rt,
                                     input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT encodeJ(input logic [11:0] target);
        return {opJmp, target};
    endfunction

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(input string name, input string what, input wordT expected,
                             input wordT actual);
        if (actual !== expected) begin
            stopRun($sformatf("ERROR %s %s expected %h actual %h", name, what, expected, actual));
        end
    endtask

    task automatic checkCount(input string name, input string what, input wordT expected,
                              input wordT actual);
        if (actual !== expected) begin
            stopRun($sformatf("ERROR %s %s expected %0d actual %0d", name, what, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input string what, input logic expected,
                             input logic actual);
        if (actual !== expected) begin
            stopRun($sformatf("ERROR %s %s expected %b actual %b", name, what, expected, actual));
        end
    endtask

    task automatic emit(input wordT word);
        prog[curTest][curWord] = word;
        curWord++;
    endtask

    task automatic closeTest(input string name, input wordT out, input wordT count,
                             input memCheckT check, input wordT addr);
        testName[curTest] = name;
        progLen[curTest]  = curWord;
        expOut[curTest]   = out;
        expCount[curTest] = count;
        memCheck[curTest] = check;
        memAddr[curTest]  = addr;
        curTest++;
        curWord = 0;
    endtask

    task automatic buildTests();
        emit(encodeI(opLhi, 0, 1, 8'h12));      // r1 = 1200
        emit(encodeI(opOri, 1, 1, 8'h34));      // r1 = 1234
        emit(encodeI(opAdi, 1, 2, 8'hF0));      // r2 = 1224 with imm -16
        emit(encodeR(funcSub, 1, 2, 3));        // r3 = 0010
        emit(encodeR(funcAnd, 1, 2, 0));        // r0 = 1224
        emit(encodeR(funcNot, 0, 0, 0));        // r0 = eddb
        emit(encodeR(funcAdd, 3, 0, 3));        // r3 = edeb
        emit(encodeR(funcTcp, 3, 0, 3));        // r3 = 1215
        emit(encodeR(funcShl, 3, 0, 2));        // r2 = 242a
        emit(encodeR(funcOrr, 2, 0, 2));        // r2 = edfb
        emit(encodeR(funcShr, 2, 0, 2));        // r2 = f6fd keeping the sign bit
        emit(encodeR(funcWwd, 2, 0, 0));
        emit(encodeR(funcHlt, 0, 0, 0));
        closeTest("aluChain", 16'hF6FD, 16'd13, memNone, '0);

        emit(encodeI(opAdi, 0, 2, 8'h03));
        emit(encodeI(opLwd, 0, 1, 8'h05));      // r1 = mem[5]
        emit(encodeR(funcAdd, 2, 1, 3));        // needs the load so one stall
        emit(encodeR(funcWwd, 3, 0, 0));
        emit(encodeR(funcHlt, 0, 0, 0));
        closeTest("loadUse", 16'h0003, 16'd5, memLoad, 16'h0005);

        emit(encodeI(opLhi, 0, 1, 8'hA5));
        emit(encodeI(opOri, 1, 1, 8'h5A));      // r1 = a55a
        emit(encodeI(opAdi, 0, 2, 8'h10));      // base 0x10
        emit(encodeI(opSwd, 2, 1, 8'h04));      // mem[14] = r1
        emit(encodeI(opLwd, 0, 3, 8'h14));
        emit(encodeR(funcWwd, 3, 0, 0));
        emit(encodeR(funcHlt, 0, 0, 0));
        closeTest("storeLoad", 16'hA55A, 16'd7, memStore, 16'h0014);

        emit(encodeI(opAdi, 0, 1, 8'h05));
        emit(encodeI(opAdi, 0, 2, 8'h05));
        emit(encodeI(opBeq, 1, 2, 8'h02));      // taken to 5
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeI(opBne, 1, 0, 8'h02));      // taken to 8
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeR(funcWwd, 1, 0, 0));
        emit(encodeR(funcHlt, 0, 0, 0));
        closeTest("branchTaken", 16'h0005, 16'd6, memNone, '0);

        emit(encodeI(opAdi, 0, 1, 8'h05));
        emit(encodeI(opAdi, 0, 2, 8'h06));
        emit(encodeI(opBeq, 1, 2, 8'h02));      // 5 vs 6 falls through
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeI(opBne, 1, 2, 8'h02));      // 6 vs 6 falls through
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeI(opBgz, 0, 0, 8'h01));      // zero is not greater
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeI(opBlz, 1, 0, 8'h01));
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeR(funcWwd, 1, 0, 0));
        emit(encodeR(funcHlt, 0, 0, 0));
        closeTest("branchNotTaken", 16'h0009, 16'd12, memNone, '0);

        emit(encodeI(opAdi, 0, 1, 8'hFD));      // r1 = -3
        emit(encodeI(opBlz, 1, 0, 8'h02));      // taken to 4
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeR(funcTcp, 1, 0, 2));        // r2 = 3
        emit(encodeI(opBgz, 2, 0, 8'h02));      // taken to 8
        emit(encodeI(opAdi, 2, 2, 8'h01));
        emit(encodeI(opAdi, 2, 2, 8'h01));
        emit(encodeR(funcWwd, 2, 0, 0));
        emit(encodeR(funcHlt, 0, 0, 0));
        closeTest("signBranch", 16'h0003, 16'd6, memNone, '0);

        emit(encodeI(opAdi, 0, 1, 8'h07));
        emit(encodeJ(12'd6));
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeI(opAdi, 1, 1, 8'h01));
        emit(encodeR(funcWwd, 1, 0, 0));
        emit(encodeR(funcHlt, 0, 0, 0));
        closeTest("jumpOver", 16'h0007, 16'd4, memNone, '0);
    endtask

    task automatic fillData();
        logic [31:0] state;
        state = lcgSeed;
        for (int a = 0; a < memDepth; a++) begin
            state   = nextLcg(state);
            dmem[a] = state[31:16] ^ wordT'(a);
        end
    endtask

    task automatic runTest(input int t);
        wordT expected;
        wordT retired;
        for (int a = 0; a < memDepth; a++) begin
            imem[a] = ~wordT'(a);                // a stray fetch would retire and move numInst
        end
        for (int a = 0; a < progLen[t]; a++) begin
            imem[a] = prog[t][a];
        end
        fillData();
        expected = expOut[t];
        if (memCheck[t] == memLoad) begin
            expected = expected + dmem[memAddr[t]];
        end
        @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkFlag(testName[t], "instrRead after reset", 1'b1, instrRead);
        while (!halted) begin
            @(negedge clk);
        end
        checkWord(testName[t], "outputPort", expected, outputPort);
        checkCount(testName[t], "numInst", expCount[t], numInst);
        retired = numInst;
        repeat (20) @(negedge clk);
        checkFlag(testName[t], "halted after 20 cycles", 1'b1, halted);
        checkFlag(testName[t], "instrRead while halted", 1'b0, instrRead);
        checkCount(testName[t], "numInst after halt", retired, numInst);
        if (memCheck[t] == memStore) begin
            checkWord(testName[t], "stored word", expOut[t], dmem[memAddr[t]]);
        end
    endtask

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        buildTests();
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
cpuPkg.sv
fetchStage.sv
controlUnit.sv
regFile.sv
executeStage.sv
memWbStage.sv
cpuCore.sv
cpuCore_chk.sv
cpuCore_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - cpuPkg.sv
  - fetchStage.sv
  - controlUnit.sv
  - regFile.sv
  - executeStage.sv
  - memWbStage.sv
  - cpuCore.sv
  - target: test
    files:
      - cpuCore_chk.sv
      - cpuCore_tb.sv
